// File: hex_pkg.sv
/*
 * shared widths, vector types and the summer state encoding
 * for the banked score table and its add-up engine
 */

package hex_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	parameter int DATA_WIDTH = 32;      // one score word
	parameter int PARALLEL_MAX = 16;    // most banks the index type can name
	parameter int ADDR_WIDTH_MAX = 13;  // deepest bank, 8192 words

	//////////////////////////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////////////////////////

	// a single score word as stored in one bank
	typedef logic [DATA_WIDTH-1:0] score_t;

	// four guard bits so sixteen full-scale scores add without overflow
	typedef logic [DATA_WIDTH+3:0] sum_t;

	// bank row, modules only look at the low ADDR_WIDTH bits
	typedef logic [ADDR_WIDTH_MAX-1:0] addr_t;

	typedef logic [$clog2(PARALLEL_MAX)-1:0] bank_idx_t;

	//////////////////////////////////////////////////////////////////////
	// score summer FSM
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,  // banks still owned by the host loader
		RUN,   // walking the rows and emitting sums
		DONE   // last sum taken, waits here until reset
	} summer_state_t;

endpackage

// File: bank_if.sv
/*
 * connection between the preload writer, the score banks
 * and the score summer
 */

`timescale 1ns/10ps

interface bank_if #(
	parameter int PARALLEL = 4,
	parameter int ADDR_WIDTH = 4
);

	// host side write port, owned by the writer until loaded
	logic wr_en;
	hex_pkg::bank_idx_t wr_bank;
	hex_pkg::addr_t wr_addr;
	hex_pkg::score_t wr_data;
	logic loaded;  // ownership passes to the engine side once this is high

	// engine side read port, same row in every bank
	logic rd_en;
	hex_pkg::addr_t rd_addr;
	hex_pkg::score_t rd_data [PARALLEL];

	// the rows actually decoded by the memories
	logic [ADDR_WIDTH-1:0] wr_row;
	logic [ADDR_WIDTH-1:0] rd_row;

	assign wr_row = wr_addr[ADDR_WIDTH-1:0];
	assign rd_row = rd_addr[ADDR_WIDTH-1:0];

	modport writer (output wr_en, wr_bank, wr_addr, wr_data, loaded);

	modport store (
		input wr_en, wr_bank, wr_row, wr_data, loaded, rd_en, rd_row,
		output rd_data
	);

	modport reader (input loaded, rd_data, output rd_en, rd_addr);

endinterface

// File: preload_writer.sv
/*
 * host score loader that spreads incoming words round robin over
 * the banks and hands them to the engine after the final word
 */

`timescale 1ns/10ps

module preload_writer #(
	parameter int PARALLEL = 4,
	parameter int ADDR_WIDTH = 4
) (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_load_valid,
	output logic            o_load_ready,
	input  hex_pkg::score_t i_load_data,
	bank_if.writer          bank
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;
	localparam hex_pkg::bank_idx_t LAST_BANK = hex_pkg::bank_idx_t'(PARALLEL - 1);
	localparam logic [ADDR_WIDTH-1:0] LAST_ROW = ADDR_WIDTH'(DEPTH - 1);

	hex_pkg::bank_idx_t bank_cnt;    // bank that takes the next word
	logic [ADDR_WIDTH-1:0] addr_cnt; // row inside that bank
	logic loaded;
	logic accept;

	assign o_load_ready = !loaded;  // host may write until the table is full
	assign accept = i_load_valid && o_load_ready;

	//////////////////////////////////////////////////////////////////////
	// the bank sees each write on the edge the beat is accepted
	//////////////////////////////////////////////////////////////////////

	assign bank.wr_en = accept;
	assign bank.wr_bank = bank_cnt;
	assign bank.wr_addr = hex_pkg::addr_t'(addr_cnt);
	assign bank.wr_data = i_load_data;
	assign bank.loaded = loaded;

	//////////////////////////////////////////////////////////////////////
	// word position counters and the ownership flag
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			bank_cnt <= '0;
			addr_cnt <= '0;
			loaded <= 1'b0;
		end else if (accept) begin
			if (bank_cnt == LAST_BANK) begin
				bank_cnt <= '0;
				addr_cnt <= addr_cnt + 1'b1;  // next row once every bank has a word
				if (addr_cnt == LAST_ROW)
					loaded <= 1'b1;  // final word of the last row
			end else begin
				bank_cnt <= bank_cnt + 1'b1;
			end
		end
	end

	// after the handover no host write reaches the banks and both position
	// counters have wrapped back to the first word of the table
	a_no_write_after_load: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		loaded |-> !bank.wr_en && bank_cnt == '0 && addr_cnt == '0
	);

endmodule

// File: score_banks.sv
/*
 * PARALLEL simple dual port score memories, one host write port
 * and a common registered read row for the summer
 */

`timescale 1ns/10ps

module score_banks #(
	parameter int PARALLEL = 4,
	parameter int ADDR_WIDTH = 4
) (
	input  logic  i_clk,
	bank_if.store bank
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	hex_pkg::score_t mem [PARALLEL][DEPTH];

	logic host_write;
	logic engine_read;

	// the loaded flag decides which side may touch the memories
	assign host_write = bank.wr_en && !bank.loaded;
	assign engine_read = bank.rd_en && bank.loaded;

	//////////////////////////////////////////////////////////////////////
	// memory arrays
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		for (int b = 0; b < PARALLEL; b++) begin
			if (host_write && int'(bank.wr_bank) == b)
				mem[b][bank.wr_row] <= bank.wr_data;

			// all banks read the same row, data is out one cycle later
			if (engine_read)
				bank.rd_data[b] <= mem[b][bank.rd_row];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	a_bank_in_range: assert property (
		@(posedge i_clk)
		bank.wr_en |-> int'(bank.wr_bank) < PARALLEL
	);

	// the summer must wait for the writer to give up the banks
	a_read_after_load: assert property (
		@(posedge i_clk)
		bank.rd_en |-> bank.loaded
	);

endmodule

// File: score_summer.sv
/*
 * score add-up engine, reads one row of every bank per step and
 * presents the row sum on a valid/ready output with back-pressure
 */

`timescale 1ns/10ps

module score_summer #(
	parameter int PARALLEL = 4,
	parameter int ADDR_WIDTH = 4
) (
	input  logic           i_clk,
	input  logic           i_rst_n,
	bank_if.reader         bank,
	output logic           o_sum_valid,
	input  logic           i_sum_ready,
	output hex_pkg::sum_t  o_sum_data,
	output hex_pkg::addr_t o_sum_addr,
	output logic           o_sum_last
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;
	localparam logic [ADDR_WIDTH-1:0] LAST_ROW = ADDR_WIDTH'(DEPTH - 1);

	hex_pkg::summer_state_t state;
	logic [ADDR_WIDTH-1:0] rd_ptr;  // next row to read
	logic issued_all;               // every row has had its read
	logic pend;                     // bank read data waiting for the output register
	hex_pkg::addr_t pend_addr;
	logic pend_last;
	hex_pkg::sum_t bank_sum;
	logic out_free;
	logic issue;
	logic load_out;

	// output register is empty or hands its sum over on this edge
	assign out_free = !o_sum_valid || i_sum_ready;

	// the first read goes out in the cycle loaded is seen, ahead of the FSM
	assign issue = ((state == hex_pkg::IDLE && bank.loaded) || state == hex_pkg::RUN)
		&& !issued_all && out_free;
	assign load_out = pend && out_free;

	assign bank.rd_en = issue;
	assign bank.rd_addr = hex_pkg::addr_t'(rd_ptr);

	always_comb begin
		bank_sum = '0;
		for (int b = 0; b < PARALLEL; b++) begin
			bank_sum = bank_sum + hex_pkg::sum_t'(bank.rd_data[b]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FSM and flow control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= hex_pkg::IDLE;
			rd_ptr <= '0;
			issued_all <= 1'b0;
			pend <= 1'b0;
			o_sum_valid <= 1'b0;
		end else begin
			case (state)
				hex_pkg::IDLE: if (bank.loaded) state <= hex_pkg::RUN;
				hex_pkg::RUN: if (o_sum_valid && i_sum_ready && o_sum_last) state <= hex_pkg::DONE;
				default: state <= hex_pkg::DONE;  // one pass only, reset starts over
			endcase

			if (issue) begin
				rd_ptr <= rd_ptr + 1'b1;
				if (rd_ptr == LAST_ROW)
					issued_all <= 1'b1;
			end

			if (issue)
				pend <= 1'b1;
			else if (load_out)
				pend <= 1'b0;

			if (load_out)
				o_sum_valid <= 1'b1;
			else if (i_sum_ready)
				o_sum_valid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (issue) begin
			pend_addr <= hex_pkg::addr_t'(rd_ptr);
			pend_last <= (rd_ptr == LAST_ROW);
		end
		if (load_out) begin
			o_sum_data <= bank_sum;  // bank read registers hold while pend waits
			o_sum_addr <= pend_addr;
			o_sum_last <= pend_last;
		end
	end

	a_hold_while_stalled: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_sum_valid && !i_sum_ready |=> o_sum_valid && $stable(o_sum_data)
			&& $stable(o_sum_addr) && $stable(o_sum_last)
	);

endmodule

// File: hex_score_top.sv
/*
 * banked score table with host preload and row sum output
 */

`timescale 1ns/10ps

module hex_score_top #(
	parameter int PARALLEL = 4,
	parameter int ADDR_WIDTH = 4
) (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_load_valid,
	output logic            o_load_ready,
	input  hex_pkg::score_t i_load_data,
	output logic            o_sum_valid,
	input  logic            i_sum_ready,
	output hex_pkg::sum_t   o_sum_data,
	output hex_pkg::addr_t  o_sum_addr,
	output logic            o_sum_last
);

	bank_if #(.PARALLEL(PARALLEL), .ADDR_WIDTH(ADDR_WIDTH)) bank ();

	// host loader, owns the banks until the table is full
	preload_writer #(.PARALLEL(PARALLEL), .ADDR_WIDTH(ADDR_WIDTH)) u_writer (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_load_valid (i_load_valid),
		.o_load_ready (o_load_ready),
		.i_load_data  (i_load_data),
		.bank         (bank.writer)
	);

	score_banks #(.PARALLEL(PARALLEL), .ADDR_WIDTH(ADDR_WIDTH)) u_banks (
		.i_clk (i_clk),
		.bank  (bank.store)
	);

	score_summer #(.PARALLEL(PARALLEL), .ADDR_WIDTH(ADDR_WIDTH)) u_summer (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.bank        (bank.reader),
		.o_sum_valid (o_sum_valid),
		.i_sum_ready (i_sum_ready),
		.o_sum_data  (o_sum_data),
		.o_sum_addr  (o_sum_addr),
		.o_sum_last  (o_sum_last)
	);

endmodule

// File: tb_hex_score.sv
/*
 * self-checking testbench for the banked score table with a test table,
 * load gaps, sink stalls and row sum checks
 */

`timescale 1ns/10ps

module tb_hex_score;

	localparam int PARALLEL = 4;
	localparam int ADDR_WIDTH = 4;
	localparam int DEPTH = 2 ** ADDR_WIDTH;
	localparam int TOTAL = PARALLEL * DEPTH;
	localparam int PAT_RAMP = 0;
	localparam int PAT_LFSR = 1;
	localparam int PAT_ONES = 2;
	localparam int ROWS = 5;
	localparam int CYCLE_LIMIT = ROWS * (TOTAL * 3 + DEPTH * 4 + 50);

	logic i_clk;
	logic i_rst_n;
	logic i_load_valid;
	logic o_load_ready;
	hex_pkg::score_t i_load_data;
	logic o_sum_valid;
	logic i_sum_ready;
	hex_pkg::sum_t o_sum_data;
	hex_pkg::addr_t o_sum_addr;
	logic o_sum_last;

	//////////////////////////////////////////////////////////////////////
	// one row per test
	//////////////////////////////////////////////////////////////////////

	string row_name [ROWS] = '{
		"ramp_flow", "lfsr_flow", "ramp_stall", "lfsr_stall", "ones_stall"
	};
	int row_pat [ROWS] = '{PAT_RAMP, PAT_LFSR, PAT_RAMP, PAT_LFSR, PAT_ONES};
	bit row_stall [ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

	logic [31:0] lfsr_state = 32'h328d_4a25;
	int cycles = 0;
	int value_errs = 0;
	int proto_errs = 0;
	hex_pkg::score_t words [TOTAL];
	hex_pkg::sum_t exp_sum [DEPTH];

	hex_score_top #(.PARALLEL(PARALLEL), .ADDR_WIDTH(ADDR_WIDTH)) i_hex_score_top (.*);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped handshaking", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Fibonacci LFSR on taps 32 22 2 1 that steps once for each bit it hands out
	function automatic logic lfsr_next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic hex_pkg::score_t lfsr_word();
		hex_pkg::score_t w;
		w = '0;
		for (int i = 0; i < hex_pkg::DATA_WIDTH; i++)
			w = {w[hex_pkg::DATA_WIDTH-2:0], lfsr_next_bit()};
		return w;
	endfunction

	task automatic step_cycle();
		@(posedge i_clk);
		#1;  // inputs change and outputs are read away from the edge
	endtask

	task automatic check_sum(input string test, input hex_pkg::sum_t exp,
		input hex_pkg::sum_t act);
		if (act !== exp) begin
			$display("[FAIL] %s sum: expected %h, got %h", test, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_addr(input string test, input hex_pkg::addr_t exp,
		input hex_pkg::addr_t act);
		if (act !== exp) begin
			$display("[FAIL] %s addr: expected %0d, got %0d", test, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_flag(input string test, input bit exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s last: expected %b, got %b", test, exp, act);
			value_errs++;
		end
	endtask

	task automatic protocol_error(input string msg);
		$display("%s", msg);
		proto_errs++;
	endtask

	// builds the words of one test and the row sums they must give
	task automatic fill_words(input int pat);
		for (int k = 0; k < TOTAL; k++) begin
			case (pat)
				PAT_RAMP: words[k] = hex_pkg::score_t'(k * 32'h0101_0003);
				PAT_LFSR: words[k] = lfsr_word();
				default: words[k] = '1;
			endcase
		end
		for (int a = 0; a < DEPTH; a++) begin
			exp_sum[a] = '0;
			for (int b = 0; b < PARALLEL; b++)
				exp_sum[a] = exp_sum[a] + hex_pkg::sum_t'(words[a * PARALLEL + b]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int idx;
		int got;
		bit stuck;
		bit was_stalled;
		logic v;
		logic l;
		hex_pkg::sum_t d;
		hex_pkg::addr_t a;
		hex_pkg::sum_t held_d;
		hex_pkg::addr_t held_a;
		logic held_l;
		string name;

		i_rst_n = 1'b0;
		i_load_valid = 1'b0;
		i_load_data = '0;
		i_sum_ready = 1'b0;
		held_d = '0;
		held_a = '0;
		held_l = 1'b0;

		for (int r = 0; r < ROWS; r++) begin
			name = row_name[r];
			fill_words(row_pat[r]);
			i_rst_n = 1'b0;
			i_load_valid = 1'b0;
			i_sum_ready = 1'b0;
			repeat (3) step_cycle();
			i_rst_n = 1'b1;
			if (o_load_ready !== 1'b1 || o_sum_valid !== 1'b0)
				protocol_error($sformatf("%s: wrong ready or valid right after reset", name));

			// about one load cycle in four is left idle
			idx = 0;
			stuck = 1'b0;
			while (idx < TOTAL && !stuck) begin
				i_load_valid = !(lfsr_next_bit() & lfsr_next_bit());
				i_load_data = words[idx];
				if (o_sum_valid)
					protocol_error($sformatf("%s: sum output active during load", name));
				if (o_load_ready !== 1'b1) begin
					protocol_error($sformatf("%s: load ready dropped after %0d of %0d words",
						name, idx, TOTAL));
					stuck = 1'b1;
				end else begin
					step_cycle();
					if (i_load_valid)
						idx++;
				end
			end
			i_load_valid = 1'b0;
			if (o_load_ready !== 1'b0)
				protocol_error($sformatf("%s: load ready still high after the last word", name));

			// first sum is due two cycles after the table fills
			step_cycle();
			if (o_sum_valid !== 1'b0)
				protocol_error($sformatf("%s: first sum came too early", name));
			step_cycle();
			if (o_sum_valid !== 1'b1)
				protocol_error($sformatf("%s: first sum not there two cycles after load", name));

			got = 0;
			was_stalled = 1'b0;
			while (got < DEPTH) begin
				i_sum_ready = row_stall[r] ? lfsr_next_bit() : 1'b1;
				v = o_sum_valid;
				d = o_sum_data;
				a = o_sum_addr;
				l = o_sum_last;
				if (o_load_ready !== 1'b0)
					protocol_error($sformatf("%s: load ready came back during the sums", name));
				if (was_stalled && !v)
					protocol_error($sformatf("%s: sum valid dropped while stalled", name));
				else if (was_stalled) begin
					check_sum({name, " hold"}, held_d, d);
					check_addr({name, " hold"}, held_a, a);
					check_flag({name, " hold"}, held_l, l);
				end
				was_stalled = v && !i_sum_ready;
				held_d = d;
				held_a = a;
				held_l = l;
				step_cycle();
				if (v && i_sum_ready) begin
					check_sum(name, exp_sum[got], d);
					check_addr(name, hex_pkg::addr_t'(got), a);
					check_flag(name, got == DEPTH - 1, l);
					got++;
				end
			end

			// nothing more may come out once the pass is over
			i_sum_ready = 1'b1;
			repeat (8) begin
				step_cycle();
				if (o_sum_valid !== 1'b0)
					protocol_error($sformatf("%s: extra sum after the last one", name));
			end
		end

		$display("%0d value errors, %0d protocol errors", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: sim.f
hex_pkg.sv
bank_if.sv
preload_writer.sv
score_banks.sv
score_summer.sv
hex_score_top.sv
tb_hex_score.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_hex_score
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
